// File: src.f
+incdir+.
cache_pkg.sv
cache_lane.sv
cache_store.sv
cache_ctrl.sv
cache_top.sv
cache_asserts.sv
tb_cache.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_cache -f src.f \
    && ./obj_dir/Vtb_cache | tee sim.log
grep -qs '^\*\* PASS \*\*$' sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: tb_cache.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module tb_cache;

    logic                clk;
    logic                rstn;
    logic                cpu_req;
    cache_pkg::cpu_cmd_t cpu_cmd;
    logic                cpu_ready;
    logic [31:0]         cpu_rdata;
    logic                cpu_rvalid;
    logic                mem_req;
    cache_pkg::mem_cmd_t mem_cmd;
    logic                mem_gnt;
    logic                mem_rvalid;
    cache_pkg::line_t    mem_rdata;

    integer                    seed = 95237;
    int                        extra_delay;               // Added to every memory latency
    cache_pkg::mem_cmd_t       mem_log [$];               // Commands granted by memory
    cache_pkg::line_t          mem_lines [logic [31:0]];
    logic [7:0]                gold [logic [31:0]];       // Bytes written by stores
    logic [`CACHE_N_LINES-1:0] shadow_valid;
    logic [`CACHE_N_LINES-1:0] shadow_dirty;
    logic [`CACHE_TAG_W-1:0]   shadow_tag [`CACHE_N_LINES];

    cache_top u_cache_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int nbytes(input cache_pkg::size_e size);
        case (size)
            cache_pkg::SIZE_BYTE: return 1;
            cache_pkg::SIZE_HALF: return 2;
            default: return 4;
        endcase
    endfunction

    // Untouched memory shows every address bit in its data
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        logic [31:0] w;
        w = {a[31:2], 2'b00};
        w = w ^ {w[15:0], w[31:16]} ^ 32'h6C3A_95E1;
        return w[{a[1:0], 3'b000} +: 8];
    endfunction

    function automatic logic [7:0] gold_byte(input logic [31:0] a);
        return gold.exists(a) ? gold[a] : fill_byte(a);
    endfunction

    function automatic cache_pkg::line_t gold_line(input logic [31:0] a);
        cache_pkg::line_t l;
        for (int k = 0; k < `CACHE_LINE_BYTES; k++) begin
            l[8*k +: 8] = gold_byte(a + 32'(k));
        end
        return l;
    endfunction

    function automatic cache_pkg::line_t read_line(input logic [31:0] a);
        cache_pkg::line_t l;
        if (mem_lines.exists(a)) begin
            return mem_lines[a];
        end
        for (int k = 0; k < `CACHE_LINE_BYTES; k++) begin
            l[8*k +: 8] = fill_byte(a + 32'(k));
        end
        return l;
    endfunction

    function automatic logic [31:0] gold_load(input logic [31:0] a, input cache_pkg::size_e size);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < nbytes(size); k++) begin
            r[8*k +: 8] = gold_byte(a + 32'(k));
        end
        return r;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_word(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            abort_run($sformatf("** Error at %0t ns: %s read 0x%08h, expected 0x%08h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_mem_cmd(input cache_pkg::mem_cmd_t actual,
                                 input cache_pkg::mem_cmd_t expected, input string what);
        if (actual !== expected) begin
            abort_run({$sformatf("** Error at %0t ns: %s got write=%0b addr=0x%08h data=0x%h",
                                 $time, what, actual.write, actual.addr, actual.wdata),
                       $sformatf(", expected write=%0b addr=0x%08h data=0x%h",
                                 expected.write, expected.addr, expected.wdata)});
        end
    endtask

    // Memory model with a random grant delay and a late refill
    initial begin
        int               gnt_wait;
        int               rd_wait;
        logic             gnt_armed;
        logic             rd_pending;
        cache_pkg::line_t rd_line;
        mem_gnt    = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        gnt_wait   = 0;
        rd_wait    = 0;
        gnt_armed  = 1'b0;
        rd_pending = 1'b0;
        rd_line    = '0;
        forever begin
            @(posedge clk);
            #2;
            mem_gnt    = 1'b0;
            mem_rvalid = 1'b0;
            if (rd_pending) begin
                if (rd_wait == 0) begin
                    mem_rvalid = 1'b1;
                    mem_rdata  = rd_line;
                    rd_pending = 1'b0;
                end else begin
                    rd_wait--;
                end
            end else if (mem_req) begin
                if (!gnt_armed) begin
                    gnt_wait  = rand_below(4) + extra_delay;
                    gnt_armed = 1'b1;
                end
                if (gnt_wait == 0) begin
                    mem_gnt   = 1'b1;
                    gnt_armed = 1'b0;
                    mem_log.push_back(mem_cmd);
                    if (mem_cmd.write) begin
                        mem_lines[mem_cmd.addr] = mem_cmd.wdata;
                    end else begin
                        rd_line    = read_line(mem_cmd.addr);
                        rd_pending = 1'b1;
                        rd_wait    = rand_below(3) + extra_delay;
                    end
                end else begin
                    gnt_wait--;
                end
            end
        end
    end

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (cpu_ready !== 1'b1) begin
            cycles++;
            if (cycles > 200) begin
                abort_run($sformatf("Timeout at %0t ns: cpu_ready did not return after a miss",
                                    $time));
            end
            @(negedge clk);
        end
    endtask

    // One CPU access checked against the shadow tags and golden bytes
    task automatic do_access(input logic write, input logic [31:0] addr,
                             input cache_pkg::size_e size, input logic [31:0] val);
        logic [`CACHE_IDX_W-1:0] idx;
        logic [`CACHE_TAG_W-1:0] tag;
        logic                    is_hit;
        logic                    wb;
        logic [31:0]             expected;
        cache_pkg::mem_cmd_t     exp_wb;
        cache_pkg::mem_cmd_t     exp_rd;
        int                      n_cmds;
        idx      = addr[`CACHE_OFF_W +: `CACHE_IDX_W];
        tag      = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
        is_hit   = shadow_valid[idx] && (shadow_tag[idx] == tag);
        wb       = !is_hit && shadow_valid[idx] && shadow_dirty[idx];
        expected = gold_load(addr, size);
        exp_wb   = '0;
        if (wb) begin
            exp_wb.write = 1'b1;
            exp_wb.addr  = {shadow_tag[idx], idx, {`CACHE_OFF_W{1'b0}}};
            exp_wb.wdata = gold_line(exp_wb.addr);
        end
        exp_rd   = '{write: 1'b0, addr: {tag, idx, {`CACHE_OFF_W{1'b0}}}, wdata: '0};
        n_cmds   = is_hit ? 0 : (wb ? 2 : 1);
        mem_log.delete();

        @(posedge clk);
        #2;
        cpu_req = 1'b1;
        cpu_cmd = '{write: write, addr: cache_pkg::addr_fields_t'(addr),
                    wdata: val << {addr[1:0], 3'b000}, size: size};  // Data in its lanes
        @(negedge clk);
        if (cpu_ready !== 1'b1) begin
            abort_run($sformatf("At %0t ns cpu_ready was low for a new request", $time));
        end
        if (is_hit && !write) begin
            if (cpu_rvalid !== 1'b1) begin
                abort_run($sformatf("At %0t ns a load hit gave no cpu_rvalid", $time));
            end
            check_word(cpu_rdata, expected, "load hit");
        end else if (cpu_rvalid !== 1'b0) begin
            abort_run($sformatf("At %0t ns cpu_rvalid rose for a store or a miss", $time));
        end
        @(posedge clk);
        #2;
        cpu_req = 1'b0;

        if (is_hit) begin
            @(negedge clk);
            if (cpu_ready !== 1'b1 || mem_req !== 1'b0) begin
                abort_run($sformatf("At %0t ns a hit stalled the cache or requested memory",
                                    $time));
            end
        end else begin
            wait_ready();
            if (!write && cpu_rvalid !== 1'b1) begin
                abort_run($sformatf("At %0t ns a load miss ended without cpu_rvalid", $time));
            end
            if (write && cpu_rvalid !== 1'b0) begin
                abort_run($sformatf("At %0t ns a store miss raised cpu_rvalid", $time));
            end
            if (!write) begin
                check_word(cpu_rdata, expected, "load miss");
            end
        end
        if (mem_log.size() != n_cmds) begin
            abort_run($sformatf("Access to 0x%08h made %0d memory requests instead of %0d",
                                addr, mem_log.size(), n_cmds));
        end
        if (wb) begin
            check_mem_cmd(mem_log[0], exp_wb, "writeback");
        end
        if (!is_hit) begin
            check_mem_cmd(mem_log[n_cmds-1], exp_rd, "refill read");
        end

        if (write) begin
            for (int k = 0; k < nbytes(size); k++) begin
                gold[addr + 32'(k)] = val[8*k +: 8];
            end
        end
        if (!is_hit) begin
            shadow_valid[idx] = 1'b1;
            shadow_tag[idx]   = tag;
            shadow_dirty[idx] = write;
        end else if (write) begin
            shadow_dirty[idx] = 1'b1;
        end
    endtask

    task automatic load_miss_then_hits();
        do_access(1'b0, 32'h0000_1008, cache_pkg::SIZE_WORD, '0);  // Clean miss with one read
        do_access(1'b0, 32'h0000_1000, cache_pkg::SIZE_WORD, '0);
        do_access(1'b0, 32'h0000_100C, cache_pkg::SIZE_WORD, '0);
        do_access(1'b0, 32'h0000_1003, cache_pkg::SIZE_BYTE, '0);
    endtask

    task automatic byte_and_half_lanes();
        logic [31:0] addr;
        for (int k = 0; k < 16; k++) begin
            do_access(1'b1, 32'h0000_2010 + 32'(k), cache_pkg::SIZE_BYTE, $random(seed));
        end
        for (int k = 0; k < 16; k += 2) begin
            do_access(1'b1, 32'h0000_2030 + 32'(k), cache_pkg::SIZE_HALF, $random(seed));
        end
        for (int b = 0; b < 2; b++) begin
            for (int k = 0; k < 16; k++) begin
                addr = 32'h0000_2010 + 32'(b * 32 + k);
                do_access(1'b0, addr, cache_pkg::SIZE_BYTE, '0);
                if (k % 2 == 0) begin
                    do_access(1'b0, addr, cache_pkg::SIZE_HALF, '0);
                end
                if (k % 4 == 0) begin
                    do_access(1'b0, addr, cache_pkg::SIZE_WORD, '0);
                end
            end
        end
    endtask

    task automatic store_miss_allocate();
        do_access(1'b1, 32'h0000_3024, cache_pkg::SIZE_WORD, 32'hCAFE_0123);  // Allocates
        do_access(1'b0, 32'h0000_3024, cache_pkg::SIZE_WORD, '0);
        do_access(1'b0, 32'h0000_3020, cache_pkg::SIZE_WORD, '0);
    endtask

    task automatic dirty_line_evict();
        do_access(1'b0, 32'h0000_5010, cache_pkg::SIZE_WORD, '0);  // Writes back 0x2010
        do_access(1'b0, 32'h0000_2014, cache_pkg::SIZE_WORD, '0);
        do_access(1'b1, 32'h0000_7022, cache_pkg::SIZE_HALF, 32'h0000_BEEF);
        do_access(1'b0, 32'h0000_3024, cache_pkg::SIZE_WORD, '0);
    endtask

    task automatic random_backpressure();
        logic [31:0]      addr;
        cache_pkg::size_e size;
        int               off;
        for (int round = 0; round < 2; round++) begin
            extra_delay = round * 4;
            for (int i = 0; i < 30; i++) begin
                size = cache_pkg::size_e'(2'(rand_below(3)));
                off  = rand_below(16) & ~(nbytes(size) - 1);
                addr = 32'h0000_8000 + 32'(rand_below(3) * 64 + rand_below(4) * 16 + off);
                do_access(rand_below(2) == 1, addr, size, $random(seed));
            end
        end
        extra_delay = 0;
    endtask

    initial begin
        rstn         = 1'b0;
        cpu_req      = 1'b0;
        cpu_cmd      = '0;
        extra_delay  = 0;
        shadow_valid = '0;
        shadow_dirty = '0;
        repeat (3) @(posedge clk);
        #2;
        rstn = 1'b1;
        load_miss_then_hits();
        byte_and_half_lanes();
        store_miss_allocate();
        dirty_line_evict();
        random_backpressure();
        $display("** PASS **");
        $finish;
    end

endmodule

// File: cache_asserts.sv
`timescale 1ns/1ns

module cache_asserts (
    input logic                clk,
    input logic                rstn,
    input logic                mem_req,
    input cache_pkg::mem_cmd_t mem_cmd,
    input logic                mem_gnt,
    input logic                cpu_ready,
    input logic                cpu_rvalid
);

    // Request and command held until the grant
    req_held: assert property (@(posedge clk) disable iff (!rstn)
        (mem_req && !mem_gnt) |=> (mem_req && $stable(mem_cmd)))
        else $error("mem_req or mem_cmd changed before mem_gnt");

    reset_quiet: assert property (@(posedge clk)
        $rose(rstn) |-> (!mem_req && !cpu_rvalid))
        else $error("mem_req or cpu_rvalid high in the first cycle after reset");

    rvalid_with_ready: assert property (@(posedge clk) disable iff (!rstn)
        cpu_rvalid |-> cpu_ready)
        else $error("cpu_rvalid high while cpu_ready is low");

endmodule

bind cache_top cache_asserts u_asserts (
    .clk        (clk),
    .rstn       (rstn),
    .mem_req    (mem_req),
    .mem_cmd    (mem_cmd),
    .mem_gnt    (mem_gnt),
    .cpu_ready  (cpu_ready),
    .cpu_rvalid (cpu_rvalid)
);

// File: cache_top.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module cache_top (
    input  logic                clk,
    input  logic                rstn,

    input  logic                cpu_req,
    input  cache_pkg::cpu_cmd_t cpu_cmd,
    output logic                cpu_ready,
    output logic [31:0]         cpu_rdata,
    output logic                cpu_rvalid,

    output logic                mem_req,
    output cache_pkg::mem_cmd_t mem_cmd,
    input  logic                mem_gnt,
    input  logic                mem_rvalid,
    input  cache_pkg::line_t    mem_rdata
);

    logic [`CACHE_IDX_W-1:0]  lookup_idx;
    logic [`CACHE_TAG_W-1:0]  lookup_tag;
    logic                     hit;
    logic                     victim_dirty;
    logic [`CACHE_ADDR_W-1:0] victim_addr;
    cache_pkg::line_t         victim_line;

    logic                     wr_en;
    logic [`CACHE_IDX_W-1:0]  wr_idx;
    logic [`CACHE_TAG_W-1:0]  wr_tag;
    cache_pkg::line_t         wr_line;
    logic                     wr_dirty;

    logic [31:0]              hit_load_word;
    cache_pkg::line_t         hit_merged_line;
    cache_pkg::line_t         fill_line;
    cache_pkg::addr_fields_t  fill_fields;
    cache_pkg::size_e         fill_size;
    logic [31:0]              fill_wdata;
    logic [31:0]              fill_load_word;
    cache_pkg::line_t         fill_merged_line;

    cache_ctrl u_ctrl (.*);

    cache_store u_store (.*);

    // Indexed line, looked up with the live CPU address
    cache_lane u_hit_lane (
        .line        (victim_line),
        .fields      (cpu_cmd.addr),
        .size        (cpu_cmd.size),
        .wdata       (cpu_cmd.wdata),
        .load_word   (hit_load_word),
        .merged_line (hit_merged_line)
    );

    // Refill data from memory
    cache_lane u_fill_lane (
        .line        (fill_line),
        .fields      (fill_fields),
        .size        (fill_size),
        .wdata       (fill_wdata),
        .load_word   (fill_load_word),
        .merged_line (fill_merged_line)
    );

endmodule

// File: cache_ctrl.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module cache_ctrl (
    input  logic                     clk,
    input  logic                     rstn,

    input  logic                     cpu_req,
    input  cache_pkg::cpu_cmd_t      cpu_cmd,
    output logic                     cpu_ready,
    output logic [31:0]              cpu_rdata,
    output logic                     cpu_rvalid,

    output logic                     mem_req,
    output cache_pkg::mem_cmd_t      mem_cmd,
    input  logic                     mem_gnt,
    input  logic                     mem_rvalid,
    input  cache_pkg::line_t         mem_rdata,

    output logic [`CACHE_IDX_W-1:0]  lookup_idx,
    output logic [`CACHE_TAG_W-1:0]  lookup_tag,
    input  logic                     hit,
    input  logic                     victim_dirty,
    input  logic [`CACHE_ADDR_W-1:0] victim_addr,
    input  cache_pkg::line_t         victim_line,

    output logic                     wr_en,
    output logic [`CACHE_IDX_W-1:0]  wr_idx,
    output logic [`CACHE_TAG_W-1:0]  wr_tag,
    output cache_pkg::line_t         wr_line,
    output logic                     wr_dirty,

    input  logic [31:0]              hit_load_word,
    input  cache_pkg::line_t         hit_merged_line,

    output cache_pkg::line_t         fill_line,
    output cache_pkg::addr_fields_t  fill_fields,
    output cache_pkg::size_e         fill_size,
    output logic [31:0]              fill_wdata,
    input  logic [31:0]              fill_load_word,
    input  cache_pkg::line_t         fill_merged_line
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITEBACK,
        S_REFILL
    } state_e;

    state_e                  state;
    cache_pkg::cpu_cmd_t     pend;        // Request that missed
    cache_pkg::addr_fields_t look_addr;
    logic                    idle;
    logic                    accept;
    logic                    miss;
    logic                    hit_load;
    logic                    refill_done;
    logic                    resp_valid;
    logic [31:0]             resp_data;

    function automatic logic [`CACHE_ADDR_W-1:0] line_addr(
        input cache_pkg::addr_fields_t a
    );
        return {a.tag, a.idx, {`CACHE_OFF_W{1'b0}}};
    endfunction

    assign idle        = (state == S_IDLE);
    assign accept      = idle && cpu_req;
    assign miss        = accept && !hit;
    assign hit_load    = accept && hit && !cpu_cmd.write;
    assign refill_done = (state == S_REFILL) && mem_rvalid;

    // Live address while idle, held request during a miss
    assign look_addr  = idle ? cpu_cmd.addr : pend.addr;
    assign lookup_idx = look_addr.idx;
    assign lookup_tag = look_addr.tag;

    assign cpu_ready  = idle;
    assign cpu_rvalid = hit_load || resp_valid;
    assign cpu_rdata  = resp_valid ? resp_data : hit_load_word;  // Miss response wins

    // Store hit while idle, line install at the end of a refill
    assign wr_en    = (accept && hit && cpu_cmd.write) || refill_done;
    assign wr_idx   = lookup_idx;
    assign wr_tag   = lookup_tag;
    assign wr_dirty = idle || pend.write;

    always_comb begin
        if (idle) begin
            wr_line = hit_merged_line;
        end else if (pend.write) begin
            wr_line = fill_merged_line;  // Store miss data goes into the new line
        end else begin
            wr_line = mem_rdata;
        end
    end

    assign fill_line   = mem_rdata;
    assign fill_fields = pend.addr;
    assign fill_size   = pend.size;
    assign fill_wdata  = pend.wdata;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= S_IDLE;
            mem_req    <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (miss) begin
                        mem_req <= 1'b1;
                        state   <= victim_dirty ? S_WRITEBACK : S_REFILL;
                    end
                end
                S_WRITEBACK: begin
                    if (mem_gnt) begin
                        state <= S_REFILL;  // Read request follows, mem_req stays up
                    end
                end
                S_REFILL: begin
                    if (mem_gnt) begin
                        mem_req <= 1'b0;
                    end
                    if (mem_rvalid) begin
                        resp_valid <= !pend.write;
                        state      <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            pend <= cpu_cmd;
            if (victim_dirty) begin
                mem_cmd <= '{write: 1'b1, addr: victim_addr, wdata: victim_line};
            end else begin
                mem_cmd <= '{write: 1'b0, addr: line_addr(cpu_cmd.addr), wdata: '0};
            end
        end
        if (state == S_WRITEBACK && mem_gnt) begin
            mem_cmd <= '{write: 1'b0, addr: line_addr(pend.addr), wdata: '0};
        end
        if (refill_done) begin
            resp_data <= fill_load_word;
        end
    end

endmodule

// File: cache_store.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module cache_store (
    input  logic                     clk,
    input  logic                     rstn,

    input  logic [`CACHE_IDX_W-1:0]  lookup_idx,
    input  logic [`CACHE_TAG_W-1:0]  lookup_tag,
    output logic                     hit,
    output logic                     victim_dirty,
    output logic [`CACHE_ADDR_W-1:0] victim_addr,
    output cache_pkg::line_t         victim_line,

    input  logic                     wr_en,
    input  logic [`CACHE_IDX_W-1:0]  wr_idx,
    input  logic [`CACHE_TAG_W-1:0]  wr_tag,
    input  cache_pkg::line_t         wr_line,
    input  logic                     wr_dirty
);

    logic [`CACHE_N_LINES-1:0] valid;
    logic [`CACHE_N_LINES-1:0] dirty;
    logic [`CACHE_TAG_W-1:0]   tag_mem  [`CACHE_N_LINES];
    cache_pkg::line_t          data_mem [`CACHE_N_LINES];

    assign hit          = valid[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
    assign victim_dirty = valid[lookup_idx] && dirty[lookup_idx];  // Needs writeback on miss
    assign victim_line  = data_mem[lookup_idx];

    // Resident line's own address, not the requested one
    assign victim_addr = {tag_mem[lookup_idx], lookup_idx, {`CACHE_OFF_W{1'b0}}};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
            dirty <= '0;
        end else if (wr_en) begin
            valid[wr_idx] <= 1'b1;
            dirty[wr_idx] <= wr_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx]  <= wr_tag;
            data_mem[wr_idx] <= wr_line;
        end
    end

endmodule

// File: cache_lane.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module cache_lane (
    input  cache_pkg::line_t        line,
    input  cache_pkg::addr_fields_t fields,
    input  cache_pkg::size_e        size,
    input  logic [31:0]             wdata,
    output logic [31:0]             load_word,
    output cache_pkg::line_t        merged_line
);

    logic [`CACHE_WOFF_W+4:0] base;  // Bit position of the addressed word
    logic [31:0]              word;
    logic [3:0]               strb;

    assign base = {fields.woff, 5'd0};
    assign word = line[base +: 32];

    always_comb begin
        case (size)
            cache_pkg::SIZE_BYTE: begin
                load_word = {24'h0, word[{fields.boff, 3'd0} +: 8]};
            end
            cache_pkg::SIZE_HALF: begin
                load_word = {16'h0, word[{fields.boff[1], 4'd0} +: 16]};
            end
            default: begin
                load_word = word;
            end
        endcase
    end

    always_comb begin
        case (size)
            cache_pkg::SIZE_BYTE: begin
                strb = 4'b0001 << fields.boff;
            end
            cache_pkg::SIZE_HALF: begin
                strb = fields.boff[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                strb = 4'b1111;
            end
        endcase
    end

    // Only strobed bytes change, rest of the line passes through
    always_comb begin
        merged_line = line;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged_line[base + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

endmodule

// File: cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_e;

    typedef logic [`CACHE_LINE_BYTES*8-1:0] line_t;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]  tag;
        logic [`CACHE_IDX_W-1:0]  idx;
        logic [`CACHE_WOFF_W-1:0] woff;
        logic [1:0]               boff;  // Byte within word
    } addr_fields_t;

    // Store data sits in its byte lanes already
    typedef struct packed {
        logic         write;
        addr_fields_t addr;
        logic [31:0]  wdata;
        size_e        size;
    } cpu_cmd_t;

    typedef struct packed {
        logic                    write;
        logic [`CACHE_ADDR_W-1:0] addr;  // Line aligned
        line_t                   wdata;
    } mem_cmd_t;

endpackage

// File: cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

`define CACHE_ADDR_W      32  // Byte address width
`define CACHE_LINE_BYTES  16
`define CACHE_N_LINES     4

// Field widths of a byte address, low to high: byte, word, index, tag
`define CACHE_OFF_W   ($clog2(`CACHE_LINE_BYTES))
`define CACHE_IDX_W   ($clog2(`CACHE_N_LINES))
`define CACHE_WOFF_W  ($clog2(`CACHE_LINE_BYTES / 4))  // Word within line
`define CACHE_TAG_W   (`CACHE_ADDR_W - `CACHE_OFF_W - `CACHE_IDX_W)

`endif
